// File: verilog/downsize_consts.svh
// Shared widths, burst limit and buffer depths, included by the packages and the RTL modules
`ifndef DOWNSIZE_CONSTS_SVH
`define DOWNSIZE_CONSTS_SVH

// --------------------
// Bus widths
// --------------------

`define DS_ADDR_W 32
`define DS_ID_W 4

// Wide side (master) and narrow side (slave)
`define DS_SI_DATA_W 64
`define DS_MI_DATA_W 32

// --------------------
// Limits and buffers
// --------------------

// Largest narrow INCR burst in beats
`define DS_MAX_BURST 256

`define DS_W_FIFO_DEPTH 4
`define DS_CMD_FIFO_DEPTH 2

`endif

// File: verilog/downsize_axi_pkg.sv
// AXI field types and channel encodings, imported by every module of the write downsizer
`include "downsize_consts.svh"

package downsize_axi_pkg;

  // --------------------
  // Address channel
  // --------------------

  typedef logic [`DS_ADDR_W-1:0] addr_t;
  typedef logic [`DS_ID_W-1:0] id_t;
  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [3:0] cache_t;

  localparam burst_t BURST_INCR = 2'b01;
  // Bufferable-independent bit that allows merging and splitting
  localparam cache_t CACHE_MODIFIABLE = 4'b0010;

  // --------------------
  // Data and response
  // --------------------

  typedef logic [1:0] resp_t;

  typedef logic [`DS_SI_DATA_W-1:0] si_data_t;
  typedef logic [`DS_SI_DATA_W/8-1:0] si_strb_t;
  typedef logic [`DS_MI_DATA_W-1:0] mi_data_t;
  typedef logic [`DS_MI_DATA_W/8-1:0] mi_strb_t;

endpackage

// File: verilog/downsize_int_pkg.sv
// Types passed between burst planner, FIFOs and W serializer, plus the shared address helper
package downsize_int_pkg;

  // One wide W beat as it sits in the W FIFO
  typedef struct packed {
    downsize_axi_pkg::si_data_t data;
    downsize_axi_pkg::si_strb_t strb;
    logic                       last;
  } si_beat_t;

  // One narrow burst, as issued on mst_aw
  typedef struct packed {
    downsize_axi_pkg::addr_t addr;
    downsize_axi_pkg::len_t  len;
    // Narrow beat size of the burst
    downsize_axi_pkg::size_t size;
    // Beat size of the original wide write
    downsize_axi_pkg::size_t wide_size;
    // Last burst of the wide transaction
    logic                    is_final;
  } w_desc_t;

  // Clear the address bits below the given size
  function automatic downsize_axi_pkg::addr_t align_addr(
    input downsize_axi_pkg::addr_t addr,
    input downsize_axi_pkg::size_t size
  );
    downsize_axi_pkg::addr_t mask;
    mask = (downsize_axi_pkg::addr_t'(1) << size) - downsize_axi_pkg::addr_t'(1);
    return addr & ~mask;
  endfunction

endpackage

// File: verilog/downsize_burst_planner.sv
// Turns one wide AW request into narrow AW bursts and a matching descriptor per burst
`timescale 1ns/1ns
`include "downsize_consts.svh"

module downsize_burst_planner (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  downsize_axi_pkg::id_t     slv_aw_id_i,
  input  downsize_axi_pkg::addr_t   slv_aw_addr_i,
  input  downsize_axi_pkg::len_t    slv_aw_len_i,
  input  downsize_axi_pkg::size_t   slv_aw_size_i,
  input  downsize_axi_pkg::burst_t  slv_aw_burst_i,
  input  downsize_axi_pkg::cache_t  slv_aw_cache_i,
  input  logic                      slv_aw_valid_i,
  output logic                      slv_aw_ready_o,
  output downsize_axi_pkg::id_t     mst_aw_id_o,
  output downsize_axi_pkg::addr_t   mst_aw_addr_o,
  output downsize_axi_pkg::len_t    mst_aw_len_o,
  output downsize_axi_pkg::size_t   mst_aw_size_o,
  output downsize_axi_pkg::burst_t  mst_aw_burst_o,
  output downsize_axi_pkg::cache_t  mst_aw_cache_o,
  output logic                      mst_aw_valid_o,
  input  logic                      mst_aw_ready_i,
  output downsize_int_pkg::w_desc_t desc_o,
  output logic                      desc_valid_o,
  input  logic                      desc_ready_i
);

  import downsize_axi_pkg::*;
  import downsize_int_pkg::*;

  localparam int MI_BYTES = `DS_MI_DATA_W / 8;
  localparam int MI_SIZE = $clog2(MI_BYTES);
  // Enough for 256 wide beats times any legal ratio
  localparam int CNT_W = 16;

  typedef logic [CNT_W-1:0] cnt_t;

  localparam cnt_t MAX_BEATS = cnt_t'(`DS_MAX_BURST);
  localparam addr_t CHUNK_BYTES = addr_t'(`DS_MAX_BURST * MI_BYTES);

  // Control state
  logic busy_q, aw_ready_q;
  logic aw_done_q, desc_done_q;

  // Captured request
  id_t    id_q;
  addr_t  addr_q;
  len_t   len_q;
  size_t  size_q;
  burst_t burst_q;
  cache_t cache_q;
  logic   down_q;
  cnt_t   remain_q;

  logic  accept;
  logic  is_down;
  addr_t size_mask;
  cnt_t  skip_beats;
  cnt_t  total_beats;
  logic  aw_ok, desc_ok, chunk_done, last_chunk;
  len_t  chunk_len;

  // --------------------
  // Request decode
  // --------------------

  assign accept = slv_aw_valid_i & aw_ready_q;
  assign is_down = (|(slv_aw_cache_i & CACHE_MODIFIABLE)) && (slv_aw_burst_i == BURST_INCR) &&
                   (slv_aw_size_i > size_t'(MI_SIZE));

  // Narrow beats lost below an unaligned start address
  assign size_mask = (addr_t'(1) << slv_aw_size_i) - addr_t'(1);
  assign skip_beats = cnt_t'((slv_aw_addr_i & size_mask) >> MI_SIZE);
  assign total_beats = ((cnt_t'(slv_aw_len_i) + cnt_t'(1)) << (slv_aw_size_i - size_t'(MI_SIZE)))
                       - skip_beats;

  // --------------------
  // Current chunk
  // --------------------

  assign last_chunk = !down_q || (remain_q <= MAX_BEATS);
  assign chunk_len = !down_q ? len_q :
                     last_chunk ? len_t'(remain_q - cnt_t'(1)) : len_t'(MAX_BEATS - cnt_t'(1));

  assign slv_aw_ready_o = aw_ready_q;

  assign mst_aw_id_o = id_q;
  assign mst_aw_addr_o = addr_q;
  assign mst_aw_len_o = chunk_len;
  assign mst_aw_size_o = down_q ? size_t'(MI_SIZE) : size_q;
  assign mst_aw_burst_o = burst_q;
  assign mst_aw_cache_o = cache_q;
  assign mst_aw_valid_o = busy_q & ~aw_done_q;

  assign desc_o = '{
    addr:      addr_q,
    len:       chunk_len,
    size:      mst_aw_size_o,
    wide_size: size_q,
    is_final:  last_chunk
  };
  assign desc_valid_o = busy_q & ~desc_done_q;

  // Both halves of a chunk must be taken before moving on
  assign aw_ok = aw_done_q | (mst_aw_valid_o & mst_aw_ready_i);
  assign desc_ok = desc_done_q | (desc_valid_o & desc_ready_i);
  assign chunk_done = busy_q & aw_ok & desc_ok;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      aw_ready_q  <= 1'b0;
      aw_done_q   <= 1'b0;
      desc_done_q <= 1'b0;
    end else if (!busy_q) begin
      aw_ready_q  <= ~accept;
      busy_q      <= accept;
      aw_done_q   <= 1'b0;
      desc_done_q <= 1'b0;
    end else if (chunk_done) begin
      aw_done_q   <= 1'b0;
      desc_done_q <= 1'b0;
      busy_q      <= ~last_chunk;
      aw_ready_q  <= last_chunk;
    end else begin
      aw_done_q   <= aw_ok;
      desc_done_q <= desc_ok;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q     <= slv_aw_id_i;
      addr_q   <= slv_aw_addr_i;
      len_q    <= slv_aw_len_i;
      size_q   <= slv_aw_size_i;
      burst_q  <= slv_aw_burst_i;
      cache_q  <= slv_aw_cache_i;
      down_q   <= is_down;
      remain_q <= total_beats;
    end else if (chunk_done && !last_chunk) begin
      // Later chunks start narrow-aligned
      addr_q   <= align_addr(addr_q, size_t'(MI_SIZE)) + CHUNK_BYTES;
      remain_q <= remain_q - MAX_BEATS;
    end
  end

endmodule

// File: verilog/downsize_fifo.sv
// Registered valid/ready FIFO for any payload type, used for wide W beats and descriptors
`timescale 1ns/1ns

module downsize_fifo #(
  parameter int unsigned DEPTH = 2,
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t in_data_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output payload_t out_data_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic push, pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign in_ready_o = (count_q != CNT_W'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_data_o = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      // Fill count moves only on an unmatched push or pop
      if (push && !pop) count_q <= count_q + CNT_W'(1);
      else if (pop && !push) count_q <= count_q - CNT_W'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_data_i;
  end

endmodule

// File: verilog/downsize_w_serializer.sv
// Cuts buffered wide W beats into narrow W beats, one descriptor per narrow burst
`timescale 1ns/1ns
`include "downsize_consts.svh"

module downsize_w_serializer (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  downsize_int_pkg::w_desc_t  desc_i,
  input  logic                       desc_valid_i,
  output logic                       desc_ready_o,
  input  downsize_int_pkg::si_beat_t beat_i,
  input  logic                       beat_valid_i,
  output logic                       beat_ready_o,
  output downsize_axi_pkg::mi_data_t mst_w_data_o,
  output downsize_axi_pkg::mi_strb_t mst_w_strb_o,
  output logic                       mst_w_last_o,
  output logic                       mst_w_valid_o,
  input  logic                       mst_w_ready_i
);

  import downsize_axi_pkg::*;
  import downsize_int_pkg::*;

  localparam int MI_BYTES = `DS_MI_DATA_W / 8;
  localparam int SI_BYTES = `DS_SI_DATA_W / 8;
  localparam int MI_SIZE = $clog2(MI_BYTES);
  localparam int SI_LANE_W = $clog2(SI_BYTES);

  // Position inside the current descriptor
  logic  first_q;
  addr_t addr_q;
  len_t  cnt_q;

  // Output register
  logic     out_valid_q;
  mi_data_t data_q;
  mi_strb_t strb_q;
  logic     last_q;

  addr_t    cur_addr;
  len_t     cur_cnt;
  addr_t    lane_base;
  addr_t    beat_end;
  logic     fire, is_last, crossing;
  addr_t    byte_addr [MI_BYTES];
  logic [SI_LANE_W-1:0] wide_lane [MI_BYTES];
  mi_data_t steer_data;
  mi_strb_t steer_strb;

  // First beat of a burst takes its position straight from the descriptor
  assign cur_addr = first_q ? desc_i.addr : addr_q;
  assign cur_cnt = first_q ? desc_i.len : cnt_q;
  assign is_last = (cur_cnt == '0);

  assign lane_base = align_addr(cur_addr, size_t'(MI_SIZE));
  assign beat_end = align_addr(cur_addr, desc_i.size) + (addr_t'(1) << desc_i.size);
  assign crossing = align_addr(beat_end, desc_i.wide_size) !=
                    align_addr(cur_addr, desc_i.wide_size);

  // Output register free or draining this cycle
  assign fire = desc_valid_i & beat_valid_i & (~out_valid_q | mst_w_ready_i);

  assign desc_ready_o = fire & is_last;
  assign beat_ready_o = fire & (crossing | (is_last & desc_i.is_final));

  // --------------------
  // Lane steering
  // --------------------

  always_comb begin
    steer_data = '0;
    steer_strb = '0;
    for (int l = 0; l < MI_BYTES; l++) begin
      byte_addr[l] = lane_base + addr_t'(l);
      wide_lane[l] = byte_addr[l][SI_LANE_W-1:0];
      // Bytes before the start or past the beat keep strobe 0
      if (byte_addr[l] >= cur_addr && byte_addr[l] < beat_end) begin
        steer_data[8*l +: 8] = beat_i.data[8*wide_lane[l] +: 8];
        steer_strb[l]        = beat_i.strb[wide_lane[l]];
      end
    end
  end

  // --------------------
  // Sequencing
  // --------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q     <= 1'b1;
      out_valid_q <= 1'b0;
    end else if (fire) begin
      first_q     <= is_last;
      out_valid_q <= 1'b1;
    end else if (mst_w_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      addr_q <= beat_end;
      cnt_q  <= cur_cnt - len_t'(1);
      data_q <= steer_data;
      strb_q <= steer_strb;
      last_q <= is_last;
    end
  end

  assign mst_w_data_o = data_q;
  assign mst_w_strb_o = strb_q;
  assign mst_w_last_o = last_q;
  assign mst_w_valid_o = out_valid_q;

endmodule

// File: verilog/axi_w_downsizer.sv
// Top level of the AXI write downsizer from a 64-bit master to a 32-bit slave
`timescale 1ns/1ns
`include "downsize_consts.svh"

module axi_w_downsizer (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Wide side
  input  downsize_axi_pkg::id_t      slv_aw_id_i,
  input  downsize_axi_pkg::addr_t    slv_aw_addr_i,
  input  downsize_axi_pkg::len_t     slv_aw_len_i,
  input  downsize_axi_pkg::size_t    slv_aw_size_i,
  input  downsize_axi_pkg::burst_t   slv_aw_burst_i,
  input  downsize_axi_pkg::cache_t   slv_aw_cache_i,
  input  logic                       slv_aw_valid_i,
  output logic                       slv_aw_ready_o,
  input  downsize_axi_pkg::si_data_t slv_w_data_i,
  input  downsize_axi_pkg::si_strb_t slv_w_strb_i,
  input  logic                       slv_w_last_i,
  input  logic                       slv_w_valid_i,
  output logic                       slv_w_ready_o,
  output downsize_axi_pkg::id_t      slv_b_id_o,
  output downsize_axi_pkg::resp_t    slv_b_resp_o,
  output logic                       slv_b_valid_o,
  input  logic                       slv_b_ready_i,
  // Narrow side
  output downsize_axi_pkg::id_t      mst_aw_id_o,
  output downsize_axi_pkg::addr_t    mst_aw_addr_o,
  output downsize_axi_pkg::len_t     mst_aw_len_o,
  output downsize_axi_pkg::size_t    mst_aw_size_o,
  output downsize_axi_pkg::burst_t   mst_aw_burst_o,
  output downsize_axi_pkg::cache_t   mst_aw_cache_o,
  output logic                       mst_aw_valid_o,
  input  logic                       mst_aw_ready_i,
  output downsize_axi_pkg::mi_data_t mst_w_data_o,
  output downsize_axi_pkg::mi_strb_t mst_w_strb_o,
  output logic                       mst_w_last_o,
  output logic                       mst_w_valid_o,
  input  logic                       mst_w_ready_i,
  input  downsize_axi_pkg::id_t      mst_b_id_i,
  input  downsize_axi_pkg::resp_t    mst_b_resp_i,
  input  logic                       mst_b_valid_i,
  output logic                       mst_b_ready_o
);

  import downsize_int_pkg::*;

  w_desc_t  plan_desc, fifo_desc;
  logic     plan_desc_valid, plan_desc_ready;
  logic     fifo_desc_valid, fifo_desc_ready;
  si_beat_t slv_beat, fifo_beat;
  logic     fifo_beat_valid, fifo_beat_ready;

  downsize_burst_planner u_planner (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_id_i    (slv_aw_id_i),
    .slv_aw_addr_i  (slv_aw_addr_i),
    .slv_aw_len_i   (slv_aw_len_i),
    .slv_aw_size_i  (slv_aw_size_i),
    .slv_aw_burst_i (slv_aw_burst_i),
    .slv_aw_cache_i (slv_aw_cache_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .mst_aw_id_o    (mst_aw_id_o),
    .mst_aw_addr_o  (mst_aw_addr_o),
    .mst_aw_len_o   (mst_aw_len_o),
    .mst_aw_size_o  (mst_aw_size_o),
    .mst_aw_burst_o (mst_aw_burst_o),
    .mst_aw_cache_o (mst_aw_cache_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .desc_o         (plan_desc),
    .desc_valid_o   (plan_desc_valid),
    .desc_ready_i   (plan_desc_ready)
  );

  downsize_fifo #(
    .DEPTH     (`DS_CMD_FIFO_DEPTH),
    .payload_t (w_desc_t)
  ) u_desc_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_data_i   (plan_desc),
    .in_valid_i  (plan_desc_valid),
    .in_ready_o  (plan_desc_ready),
    .out_data_o  (fifo_desc),
    .out_valid_o (fifo_desc_valid),
    .out_ready_i (fifo_desc_ready)
  );

  assign slv_beat = '{data: slv_w_data_i, strb: slv_w_strb_i, last: slv_w_last_i};

  downsize_fifo #(
    .DEPTH     (`DS_W_FIFO_DEPTH),
    .payload_t (si_beat_t)
  ) u_w_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_data_i   (slv_beat),
    .in_valid_i  (slv_w_valid_i),
    .in_ready_o  (slv_w_ready_o),
    .out_data_o  (fifo_beat),
    .out_valid_o (fifo_beat_valid),
    .out_ready_i (fifo_beat_ready)
  );

  downsize_w_serializer u_serializer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .desc_i        (fifo_desc),
    .desc_valid_i  (fifo_desc_valid),
    .desc_ready_o  (fifo_desc_ready),
    .beat_i        (fifo_beat),
    .beat_valid_i  (fifo_beat_valid),
    .beat_ready_o  (fifo_beat_ready),
    .mst_w_data_o  (mst_w_data_o),
    .mst_w_strb_o  (mst_w_strb_o),
    .mst_w_last_o  (mst_w_last_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_ready_i (mst_w_ready_i)
  );

  // B passes straight back with no latency
  assign slv_b_id_o = mst_b_id_i;
  assign slv_b_resp_o = mst_b_resp_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

// File: sim/axi_w_downsizer_assertions.sv
// Narrow-side AW and W protocol assertions, bound into the downsizer top level for simulation
`timescale 1ns/1ns

module axi_w_downsizer_assertions (
  input logic                       clk_i,
  input logic                       rst_ni,
  input downsize_axi_pkg::size_t    slv_aw_size_i,
  input downsize_axi_pkg::burst_t   slv_aw_burst_i,
  input downsize_axi_pkg::cache_t   slv_aw_cache_i,
  input logic                       slv_aw_valid_i,
  input logic                       slv_aw_ready_i,
  input downsize_axi_pkg::id_t      mst_aw_id_i,
  input downsize_axi_pkg::addr_t    mst_aw_addr_i,
  input downsize_axi_pkg::len_t     mst_aw_len_i,
  input downsize_axi_pkg::size_t    mst_aw_size_i,
  input downsize_axi_pkg::burst_t   mst_aw_burst_i,
  input downsize_axi_pkg::cache_t   mst_aw_cache_i,
  input logic                       mst_aw_valid_i,
  input logic                       mst_aw_ready_i,
  input downsize_axi_pkg::mi_data_t mst_w_data_i,
  input downsize_axi_pkg::mi_strb_t mst_w_strb_i,
  input logic                       mst_w_last_i,
  input logic                       mst_w_valid_i,
  input logic                       mst_w_ready_i
);

  import downsize_axi_pkg::*;

  // Number of property failures so far
  int unsigned fail_count = 0;

  logic [52:0] aw_payload;
  logic [36:0] w_payload;
  logic        down_q;

  assign aw_payload = {mst_aw_id_i, mst_aw_addr_i, mst_aw_len_i, mst_aw_size_i,
                       mst_aw_burst_i, mst_aw_cache_i};
  assign w_payload = {mst_w_data_i, mst_w_strb_i, mst_w_last_i};

  // Whether the write last taken on the wide AW must be downsized
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      down_q <= 1'b0;
    end else if (slv_aw_valid_i && slv_aw_ready_i) begin
      down_q <= ((slv_aw_cache_i & CACHE_MODIFIABLE) != '0) &&
                (slv_aw_burst_i == BURST_INCR) && (slv_aw_size_i > 3'd2);
    end
  end

  // Held AW stays put until taken
  aw_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_aw_valid_i && !mst_aw_ready_i |=> mst_aw_valid_i && $stable(aw_payload))
  else begin
    fail_count++;
    $error("mst_aw dropped valid or changed payload while stalled");
  end

  w_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_w_valid_i && !mst_w_ready_i |=> mst_w_valid_i && $stable(w_payload))
  else begin
    fail_count++;
    $error("mst_w dropped valid or changed payload while stalled");
  end

  // Downsized bursts use at most the narrow beat size
  aw_size_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_aw_valid_i && down_q |-> mst_aw_size_i <= 3'd2)
  else begin
    fail_count++;
    $error("mst_aw_size wider than the narrow bus on a downsized burst");
  end

endmodule

bind axi_w_downsizer axi_w_downsizer_assertions u_assertions (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .slv_aw_size_i  (slv_aw_size_i),
  .slv_aw_burst_i (slv_aw_burst_i),
  .slv_aw_cache_i (slv_aw_cache_i),
  .slv_aw_valid_i (slv_aw_valid_i),
  .slv_aw_ready_i (slv_aw_ready_o),
  .mst_aw_id_i    (mst_aw_id_o),
  .mst_aw_addr_i  (mst_aw_addr_o),
  .mst_aw_len_i   (mst_aw_len_o),
  .mst_aw_size_i  (mst_aw_size_o),
  .mst_aw_burst_i (mst_aw_burst_o),
  .mst_aw_cache_i (mst_aw_cache_o),
  .mst_aw_valid_i (mst_aw_valid_o),
  .mst_aw_ready_i (mst_aw_ready_i),
  .mst_w_data_i   (mst_w_data_o),
  .mst_w_strb_i   (mst_w_strb_o),
  .mst_w_last_i   (mst_w_last_o),
  .mst_w_valid_i  (mst_w_valid_o),
  .mst_w_ready_i  (mst_w_ready_i)
);

// File: sim/tb_axi_w_downsizer.sv
// Testbench for the AXI write downsizer, run from verilog.f with tb_axi_w_downsizer as top
`timescale 1ns/1ns
`include "downsize_consts.svh"

module tb_axi_w_downsizer;

  import downsize_axi_pkg::*;

  localparam int MAX_TX = 16;
  localparam int MAX_BEATS = 512;
  localparam int MI_BYTES = `DS_MI_DATA_W / 8;
  localparam int SI_BYTES = `DS_SI_DATA_W / 8;
  localparam int MAX_BURST = `DS_MAX_BURST;

  logic     clk_i, rst_ni;
  id_t      slv_aw_id, mst_aw_id, slv_b_id, mst_b_id;
  addr_t    slv_aw_addr, mst_aw_addr;
  len_t     slv_aw_len, mst_aw_len;
  size_t    slv_aw_size, mst_aw_size;
  burst_t   slv_aw_burst, mst_aw_burst;
  cache_t   slv_aw_cache, mst_aw_cache;
  logic     slv_aw_valid, slv_aw_ready, mst_aw_valid, mst_aw_ready;
  si_data_t slv_w_data;
  si_strb_t slv_w_strb;
  logic     slv_w_last, slv_w_valid, slv_w_ready;
  mi_data_t mst_w_data;
  mi_strb_t mst_w_strb;
  logic     mst_w_last, mst_w_valid, mst_w_ready;
  resp_t    slv_b_resp, mst_b_resp;
  logic     slv_b_valid, slv_b_ready, mst_b_valid, mst_b_ready;

  // Transaction table and wide W data
  id_t      tx_id [MAX_TX];
  addr_t    tx_addr [MAX_TX];
  len_t     tx_len [MAX_TX];
  size_t    tx_size [MAX_TX];
  cache_t   tx_cache [MAX_TX];
  int       tx_base [MAX_TX];
  si_data_t wd [MAX_BEATS];
  si_strb_t ws [MAX_BEATS];
  int       num_tx, num_beats;
  logic     table_done;

  // Expected narrow traffic, {id, addr, len, size, burst, cache} and {data, strb, last}
  logic [52:0] exp_aw_q [$];
  logic [36:0] exp_w_q [$];
  logic [52:0] exp_aw;
  logic [36:0] exp_w;
  int exp_aw_total, exp_w_total, got_aw, got_w;
  int aw_errors, w_errors, b_errors, other_errors;

  integer seed;
  int stall_pct;

  axi_w_downsizer u_axi_w_downsizer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_id_i    (slv_aw_id),
    .slv_aw_addr_i  (slv_aw_addr),
    .slv_aw_len_i   (slv_aw_len),
    .slv_aw_size_i  (slv_aw_size),
    .slv_aw_burst_i (slv_aw_burst),
    .slv_aw_cache_i (slv_aw_cache),
    .slv_aw_valid_i (slv_aw_valid),
    .slv_aw_ready_o (slv_aw_ready),
    .slv_w_data_i   (slv_w_data),
    .slv_w_strb_i   (slv_w_strb),
    .slv_w_last_i   (slv_w_last),
    .slv_w_valid_i  (slv_w_valid),
    .slv_w_ready_o  (slv_w_ready),
    .slv_b_id_o     (slv_b_id),
    .slv_b_resp_o   (slv_b_resp),
    .slv_b_valid_o  (slv_b_valid),
    .slv_b_ready_i  (slv_b_ready),
    .mst_aw_id_o    (mst_aw_id),
    .mst_aw_addr_o  (mst_aw_addr),
    .mst_aw_len_o   (mst_aw_len),
    .mst_aw_size_o  (mst_aw_size),
    .mst_aw_burst_o (mst_aw_burst),
    .mst_aw_cache_o (mst_aw_cache),
    .mst_aw_valid_o (mst_aw_valid),
    .mst_aw_ready_i (mst_aw_ready),
    .mst_w_data_o   (mst_w_data),
    .mst_w_strb_o   (mst_w_strb),
    .mst_w_last_o   (mst_w_last),
    .mst_w_valid_o  (mst_w_valid),
    .mst_w_ready_i  (mst_w_ready),
    .mst_b_id_i     (mst_b_id),
    .mst_b_resp_i   (mst_b_resp),
    .mst_b_valid_i  (mst_b_valid),
    .mst_b_ready_o  (mst_b_ready)
  );

  always #4 clk_i = ~clk_i;

  // Narrow slave with random ready stalls
  always @(posedge clk_i) begin
    mst_aw_ready <= ($unsigned($random(seed)) % 100) >= stall_pct;
    mst_w_ready  <= ($unsigned($random(seed)) % 100) >= stall_pct;
  end

  // --------------------
  // Stimulus helpers
  // --------------------

  task automatic add_tx(input id_t id, input addr_t addr, input len_t len, input size_t size,
                        input cache_t cache);
    tx_id[num_tx] = id;
    tx_addr[num_tx] = addr;
    tx_len[num_tx] = len;
    tx_size[num_tx] = size;
    tx_cache[num_tx] = cache;
    tx_base[num_tx] = num_beats;
    for (int i = 0; i <= len; i++) begin
      wd[num_beats] = {$random(seed), $random(seed)};
      ws[num_beats] = $random(seed);
      num_beats++;
    end
    num_tx++;
  endtask

  // Expected narrow AWs and W beats of one wide write
  function automatic void build_expected(input int t);
    logic        down;
    addr_t       cur, blk_end, p, pe, base;
    int          first, n, chunk;
    logic [31:0] d;
    logic [3:0]  s;
    down = ((tx_cache[t] & CACHE_MODIFIABLE) != 0) && (tx_size[t] > 3'd2);
    first = exp_w_q.size();
    cur = tx_addr[t];
    for (int i = 0; i <= tx_len[t]; i++) begin
      blk_end = ((cur >> tx_size[t]) << tx_size[t]) + (addr_t'(1) << tx_size[t]);
      p = cur;
      // Cut the wide beat at narrow boundaries when downsizing
      while (p < blk_end) begin
        pe = down ? (p - (p % MI_BYTES) + MI_BYTES) : blk_end;
        if (pe > blk_end) pe = blk_end;
        d = '0;
        s = '0;
        for (addr_t a = p; a < pe; a++) begin
          d[8*(a % MI_BYTES) +: 8] = wd[tx_base[t] + i][8*(a % SI_BYTES) +: 8];
          s[a % MI_BYTES] = ws[tx_base[t] + i][a % SI_BYTES];
        end
        exp_w_q.push_back({d, s, 1'b0});
        p = pe;
      end
      cur = blk_end;
    end
    n = exp_w_q.size() - first;
    exp_w_total += n;
    if (!down) begin
      exp_aw_q.push_back({tx_id[t], tx_addr[t], tx_len[t], tx_size[t], BURST_INCR, tx_cache[t]});
      exp_w_q[first + n - 1] = exp_w_q[first + n - 1] | 37'd1;
      exp_aw_total++;
    end else begin
      base = tx_addr[t];
      for (int k = 0; k < n; k += MAX_BURST) begin
        chunk = (n - k > MAX_BURST) ? MAX_BURST : n - k;
        exp_aw_q.push_back({tx_id[t], base, len_t'(chunk - 1), size_t'(2), BURST_INCR,
                            tx_cache[t]});
        exp_w_q[first + k + chunk - 1] = exp_w_q[first + k + chunk - 1] | 37'd1;
        base = base - (base % MI_BYTES) + addr_t'(MAX_BURST * MI_BYTES);
        exp_aw_total++;
      end
    end
  endfunction

  task automatic send_tx(input int t);
    slv_aw_id <= tx_id[t];
    slv_aw_addr <= tx_addr[t];
    slv_aw_len <= tx_len[t];
    slv_aw_size <= tx_size[t];
    slv_aw_burst <= BURST_INCR;
    slv_aw_cache <= tx_cache[t];
    slv_aw_valid <= 1'b1;
    @(posedge clk_i);
    while (!slv_aw_ready) @(posedge clk_i);
    slv_aw_valid <= 1'b0;
    for (int i = 0; i <= tx_len[t]; i++) begin
      slv_w_data <= wd[tx_base[t] + i];
      slv_w_strb <= ws[tx_base[t] + i];
      slv_w_last <= (i == tx_len[t]);
      slv_w_valid <= 1'b1;
      @(posedge clk_i);
      while (!slv_w_ready) @(posedge clk_i);
    end
    slv_w_valid <= 1'b0;
  endtask

  task automatic drain();
    while (exp_aw_q.size() != 0 || exp_w_q.size() != 0) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
  endtask

  task automatic show_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] exp, inout int count);
    $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    count++;
  endtask

  // B must pass through in the same cycle
  task automatic check_b(input id_t id, input resp_t resp, input logic ready);
    mst_b_id <= id;
    mst_b_resp <= resp;
    mst_b_valid <= 1'b1;
    slv_b_ready <= ready;
    @(negedge clk_i);
    if (slv_b_id !== id) show_mismatch("slv_b_id", slv_b_id, id, b_errors);
    if (slv_b_resp !== resp) show_mismatch("slv_b_resp", slv_b_resp, resp, b_errors);
    if (slv_b_valid !== 1'b1) show_mismatch("slv_b_valid", slv_b_valid, 1, b_errors);
    if (mst_b_ready !== ready) show_mismatch("mst_b_ready", mst_b_ready, ready, b_errors);
    @(posedge clk_i);
    mst_b_valid <= 1'b0;
    slv_b_ready <= 1'b0;
  endtask

  // --------------------
  // Compare
  // --------------------

  always @(posedge clk_i) begin
    if (rst_ni && mst_aw_valid && mst_aw_ready) begin
      got_aw++;
      if (exp_aw_q.size() == 0) begin
        $display("Narrow AW at %0t ns arrived with no burst left to expect", $time);
        aw_errors++;
      end else begin
        exp_aw = exp_aw_q.pop_front();
        if (mst_aw_id !== exp_aw[52:49])
          show_mismatch("mst_aw_id", mst_aw_id, exp_aw[52:49], aw_errors);
        if (mst_aw_addr !== exp_aw[48:17])
          show_mismatch("mst_aw_addr", mst_aw_addr, exp_aw[48:17], aw_errors);
        if (mst_aw_len !== exp_aw[16:9])
          show_mismatch("mst_aw_len", mst_aw_len, exp_aw[16:9], aw_errors);
        if (mst_aw_size !== exp_aw[8:6])
          show_mismatch("mst_aw_size", mst_aw_size, exp_aw[8:6], aw_errors);
        if (mst_aw_burst !== exp_aw[5:4])
          show_mismatch("mst_aw_burst", mst_aw_burst, exp_aw[5:4], aw_errors);
        if (mst_aw_cache !== exp_aw[3:0])
          show_mismatch("mst_aw_cache", mst_aw_cache, exp_aw[3:0], aw_errors);
      end
    end
    if (rst_ni && mst_w_valid && mst_w_ready) begin
      got_w++;
      if (exp_w_q.size() == 0) begin
        $display("Narrow W beat at %0t ns arrived with no beat left to expect", $time);
        w_errors++;
      end else begin
        exp_w = exp_w_q.pop_front();
        if (mst_w_data !== exp_w[36:5])
          show_mismatch("mst_w_data", mst_w_data, exp_w[36:5], w_errors);
        if (mst_w_strb !== exp_w[4:1])
          show_mismatch("mst_w_strb", mst_w_strb, exp_w[4:1], w_errors);
        if (mst_w_last !== exp_w[0])
          show_mismatch("mst_w_last", mst_w_last, exp_w[0], w_errors);
      end
    end
  end

  // Watchdog sized from the number of wide beats
  initial begin
    wait (table_done);
    repeat (num_beats * 4 * 20) @(posedge clk_i);
    $display("Timeout: the narrow side did not deliver all expected bursts in time");
    $display("TEST FAIL");
    $finish;
  end

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    id_t    rnd_id;
    addr_t  rnd_addr;
    len_t   rnd_len;
    size_t  rnd_size;
    cache_t rnd_cache;
    seed = 32'hb453;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    {slv_aw_id, slv_aw_addr, slv_aw_len, slv_aw_size, slv_aw_burst, slv_aw_cache} = '0;
    {slv_aw_valid, slv_w_data, slv_w_strb, slv_w_last, slv_w_valid, slv_b_ready} = '0;
    {mst_aw_ready, mst_w_ready, mst_b_id, mst_b_resp, mst_b_valid} = '0;
    {exp_aw_total, exp_w_total, got_aw, got_w} = '0;
    {aw_errors, w_errors, b_errors, other_errors} = '0;
    stall_pct = 0;
    num_tx = 0;
    num_beats = 0;
    table_done = 1'b0;
    // Aligned, unaligned, long, non-modifiable and narrow-size writes
    add_tx(4'h1, 32'h0000_1000, 8'd3, 3'd3, 4'h3);
    add_tx(4'h2, 32'h0000_2004, 8'd3, 3'd3, 4'h2);
    add_tx(4'h3, 32'h0000_4000, 8'd200, 3'd3, 4'hf);
    add_tx(4'h4, 32'h0000_5004, 8'd3, 3'd2, 4'h0);
    add_tx(4'h5, 32'h0000_6002, 8'd5, 3'd1, 4'h2);
    for (int i = 0; i < 8; i++) begin
      rnd_id = $random(seed);
      rnd_addr = $random(seed) & 32'h0fff_ffff;
      rnd_len = $unsigned($random(seed)) % 16;
      rnd_size = $unsigned($random(seed)) % 4;
      rnd_cache = $random(seed);
      if (rnd_size == 3'd3) rnd_cache = rnd_cache | CACHE_MODIFIABLE;
      add_tx(rnd_id, rnd_addr, rnd_len, rnd_size, rnd_cache);
    end
    table_done = 1'b1;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    for (int t = 0; t < 5; t++) begin
      build_expected(t);
      send_tx(t);
    end
    drain();
    // Random slave stalls from here on
    @(negedge clk_i);
    stall_pct = 40;
    @(posedge clk_i);
    for (int t = 5; t < num_tx; t++) begin
      build_expected(t);
      send_tx(t);
    end
    drain();
    check_b(4'h3, 2'b00, 1'b1);
    check_b(4'hc, 2'b10, 1'b0);
    if (got_aw != exp_aw_total || got_w != exp_w_total) begin
      $display("Beat count mismatch: %0d AW and %0d W seen, %0d AW and %0d W expected",
               got_aw, got_w, exp_aw_total, exp_w_total);
      other_errors++;
    end
    if (u_axi_w_downsizer.u_assertions.fail_count != 0) begin
      $display("Protocol assertions failed %0d times",
               u_axi_w_downsizer.u_assertions.fail_count);
      other_errors += u_axi_w_downsizer.u_assertions.fail_count;
    end
    $display("Errors: %0d AW, %0d W, %0d B, %0d other", aw_errors, w_errors, b_errors,
             other_errors);
    if (aw_errors + w_errors + b_errors + other_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+verilog
verilog/downsize_axi_pkg.sv
verilog/downsize_int_pkg.sv
verilog/downsize_burst_planner.sv
verilog/downsize_fifo.sv
verilog/downsize_w_serializer.sv
verilog/axi_w_downsizer.sv
sim/axi_w_downsizer_assertions.sv
sim/tb_axi_w_downsizer.sv

// File: Bender.yml
package:
  name: axi_w_downsizer

sources:
  - target: any(rtl, simulation)
    include_dirs:
      - verilog
    files:
      - verilog/downsize_axi_pkg.sv
      - verilog/downsize_int_pkg.sv
      - verilog/downsize_burst_planner.sv
      - verilog/downsize_fifo.sv
      - verilog/downsize_w_serializer.sv
      - verilog/axi_w_downsizer.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/axi_w_downsizer_assertions.sv
      - sim/tb_axi_w_downsizer.sv
